// ==== pcl_3w_master.f ====
common/pcl_3w_pkg.sv
common/pcl_3w_if.sv
protocol/pcl_cmd_decoder.sv
threewire/tw_serial_engine.sv
verilog/word_buffer_ram.sv
verilog/pcl_3w_master.sv
tb/tw_slave_model.sv
tb/tb_pcl_3w_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_pcl_3w_master \
  -Mdir obj_dir \
  -f pcl_3w_master.f

./obj_dir/Vtb_pcl_3w_master

// ==== tb/tb_pcl_3w_master.sv ====
/* Testbench for the host to 3W bridge: host byte link, reference model,
   reply and frame checks, run limit */
`timescale 1ns/1ps

module tb_pcl_3w_master
  import pcl_3w_pkg::*;
();

  localparam int          CLK_HALF   = 4;
  localparam int          RST_CYCLES = 5;
  // Two full 32 word bursts take about 15000 cycles
  localparam int          MAX_CYCLES = 60000;
  localparam logic [31:0] SEED       = 32'ha2f7_30cf;

  logic       in_clk  = 1'b0;
  logic       in_rst  = 1'b1;
  logic [7:0] data_rx = 8'h00;
  logic       rx_done = 1'b0;
  logic       tx_done = 1'b0;
  logic       rx_trig;
  logic       tx_trig;
  logic [7:0] data_tx;
  logic       tw_clock;
  logic       tw_cs;
  logic       tw_dout;
  logic       tw_din;
  logic       tw_dir;

  int                   frame_cnt;
  logic                 frame_rw;
  logic [ADDR_BITS-1:0] frame_addr;
  logic [DATA_BITS-1:0] frame_data;
  int                   frame_bits;
  logic                 frame_dir_ok;

  // Expected and observed traffic, walked by running indexes
  logic [7:0]           exp_reply_q[$];
  logic [7:0]           got_reply_q[$];
  logic                 exp_rw_q[$];
  logic [ADDR_BITS-1:0] exp_addr_q[$];
  logic [DATA_BITS-1:0] exp_data_q[$];
  logic                 obs_rw_q[$];
  logic [ADDR_BITS-1:0] obs_addr_q[$];
  logic [DATA_BITS-1:0] obs_data_q[$];
  int                   cmp_idx        = 0;
  int                   frames_seen    = 0;
  int                   frames_checked = 0;
  int                   rx_trig_cnt    = 0;
  int                   bytes_sent     = 0;
  int                   cycle_cnt      = 0;

  pcl_3w_master dut (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .data_rx  (data_rx),
    .rx_done  (rx_done),
    .rx_trig  (rx_trig),
    .data_tx  (data_tx),
    .tx_done  (tx_done),
    .tx_trig  (tx_trig),
    .tw_clock (tw_clock),
    .tw_cs    (tw_cs),
    .tw_dout  (tw_dout),
    .tw_din   (tw_din),
    .tw_dir   (tw_dir)
  );

  tw_slave_model slave (
    .tw_clock     (tw_clock),
    .tw_cs        (tw_cs),
    .tw_dout      (tw_dout),
    .tw_dir       (tw_dir),
    .tw_din       (tw_din),
    .frame_cnt    (frame_cnt),
    .frame_rw     (frame_rw),
    .frame_addr   (frame_addr),
    .frame_data   (frame_data),
    .frame_bits   (frame_bits),
    .frame_dir_ok (frame_dir_ok)
  );

  // Word the slave returns for a read at this address
  function automatic logic [DATA_BITS-1:0] expected_word(input logic [ADDR_BITS-1:0] addr);
    expected_word = DATA_BITS'(32'(addr) * 32'h9E3 + 32'h5A5A);
  endfunction

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    assert (got == exp)
    else
    begin
      $display("FAIL %0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Clock, run limit and monitors
  initial
  begin
    forever #CLK_HALF in_clk = ~in_clk;
  end

  always @(posedge in_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    assert (cycle_cnt < MAX_CYCLES)
    else
    begin
      $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  always @(posedge in_clk)
  begin
    if (rx_trig)
      rx_trig_cnt <= rx_trig_cnt + 1;
  end

  // Reply bytes are taken at tx_trig and acknowledged after a random delay
  initial
  begin
    forever
    begin
      @(posedge in_clk);
      if (tx_trig)
      begin
        got_reply_q.push_back(data_tx);
        repeat ($urandom_range(1, 4)) @(posedge in_clk);
        tx_done <= 1'b1;
        @(posedge in_clk);
        tx_done <= 1'b0;
      end
    end
  end

  always @(posedge in_clk)
  begin
    if (got_reply_q.size() > cmp_idx)
    begin
      assert (cmp_idx < exp_reply_q.size())
      else
      begin
        $display("Unexpected reply byte 0x%02h from the DUT", got_reply_q[cmp_idx]);
        abort_run();
      end
      compare_value("data_tx", 32'(exp_reply_q[cmp_idx]), 32'(got_reply_q[cmp_idx]));
      cmp_idx <= cmp_idx + 1;
    end
  end

  always @(posedge in_clk)
  begin
    if (frame_cnt != frames_seen)
    begin
      compare_value("frame_bits", 32'(FRAME_BITS), 32'(frame_bits));
      assert (frame_dir_ok)
      else
      begin
        $display("The 3W direction line was wrong during the frame at 0x%0h", frame_addr);
        abort_run();
      end
      obs_rw_q.push_back(frame_rw);
      obs_addr_q.push_back(frame_addr);
      obs_data_q.push_back(frame_data);
      frames_seen <= frames_seen + 1;
    end
  end

  ////////////////////////////////////////
  // Host byte link
  task automatic send_byte(input logic [7:0] b);
    // Every byte after the first waits for its rx_trig
    while (rx_trig_cnt < bytes_sent)
      @(posedge in_clk);
    repeat ($urandom_range(1, 4)) @(posedge in_clk);
    data_rx <= b;
    rx_done <= 1'b1;
    @(posedge in_clk);
    rx_done <= 1'b0;
    bytes_sent++;
  endtask

  task automatic check_frames();
    int i;
    assert (obs_rw_q.size() == exp_rw_q.size())
    else
    begin
      $display("Saw %0d 3W frames while %0d were expected", obs_rw_q.size(),
               exp_rw_q.size());
      abort_run();
    end
    for (i = frames_checked; i < exp_rw_q.size(); i++)
    begin
      compare_value("frame_rw", 32'(exp_rw_q[i]), 32'(obs_rw_q[i]));
      compare_value("frame_addr", 32'(exp_addr_q[i]), 32'(obs_addr_q[i]));
      // Read words come back through the reply bytes
      if (exp_rw_q[i])
        compare_value("frame_data", 32'(exp_data_q[i]), 32'(obs_data_q[i]));
    end
    frames_checked = exp_rw_q.size();
  endtask

  // A command is over once the decoder asks for the next byte
  task automatic finish_command();
    while (rx_trig_cnt < bytes_sent)
      @(posedge in_clk);
    repeat (4) @(posedge in_clk);
    assert (got_reply_q.size() == exp_reply_q.size())
    else
    begin
      $display("Got %0d reply bytes while %0d were expected", got_reply_q.size(),
               exp_reply_q.size());
      abort_run();
    end
    check_frames();
  endtask

  ////////////////////////////////////////
  // Commands
  task automatic ping_command();
    exp_reply_q.push_back({1'b0, OP_OK});
    send_byte({1'b0, OP_PING});
    finish_command();
  endtask

  task automatic echo_command();
    logic [7:0] b;
    repeat (20)
    begin
      b = 8'($urandom);
      exp_reply_q.push_back(b);
      send_byte({1'b0, OP_ECHO});
      send_byte(b);
      finish_command();
    end
  endtask

  task automatic write_command(input logic burst, input logic [7:0] burst_byte);
    logic [15:0]          addr_in;
    logic [ADDR_BITS-1:0] base;
    logic [DATA_BITS-1:0] word;
    int                   n;
    int                   k;
    addr_in = 16'($urandom);
    base    = addr_in[ADDR_BITS-1:0];
    n       = burst ? (int'(burst_byte) % BURST_MAX) + 1 : 1;
    exp_reply_q.push_back({1'b0, OP_OK});
    send_byte({burst, OP_WRITE});
    if (burst)
      send_byte(burst_byte);
    send_byte(addr_in[15:8]);
    send_byte(addr_in[7:0]);
    for (k = 0; k < n; k++)
    begin
      word = 16'($urandom);
      exp_rw_q.push_back(1'b1);
      exp_addr_q.push_back(base + ADDR_BITS'(k));
      exp_data_q.push_back(word);
      send_byte(word[15:8]);
      send_byte(word[7:0]);
    end
    finish_command();
  endtask

  task automatic read_command(input logic burst, input logic [7:0] burst_byte);
    logic [15:0]          addr_in;
    logic [ADDR_BITS-1:0] base;
    logic [DATA_BITS-1:0] word;
    int                   n;
    int                   k;
    addr_in = 16'($urandom);
    base    = addr_in[ADDR_BITS-1:0];
    n       = burst ? (int'(burst_byte) % BURST_MAX) + 1 : 1;
    for (k = 0; k < n; k++)
    begin
      word = expected_word(base + ADDR_BITS'(k));
      exp_rw_q.push_back(1'b0);
      exp_addr_q.push_back(base + ADDR_BITS'(k));
      exp_data_q.push_back('0);
      exp_reply_q.push_back(word[15:8]);
      exp_reply_q.push_back(word[7:0]);
    end
    send_byte({burst, OP_READ});
    if (burst)
      send_byte(burst_byte);
    send_byte(addr_in[15:8]);
    send_byte(addr_in[7:0]);
    finish_command();
  endtask

  // Unknown opcodes are swallowed with no reply and no frame
  task automatic unknown_opcodes();
    send_byte(8'h05);
    finish_command();
    send_byte(8'h7F);
    finish_command();
    ping_command();
  endtask

  initial
  begin
    void'($urandom(SEED));
    repeat (RST_CYCLES) @(posedge in_clk);
    in_rst <= 1'b0;
    repeat (2) @(posedge in_clk);
    // Outputs idle after reset
    compare_value("rx_trig", 32'(1'b0), 32'(rx_trig));
    compare_value("tx_trig", 32'(1'b0), 32'(tx_trig));
    compare_value("tw_cs", 32'(1'b1), 32'(tw_cs));
    compare_value("tw_clock", 32'(1'b0), 32'(tw_clock));
    compare_value("tw_dir", 32'(1'b1), 32'(tw_dir));
    ping_command();
    echo_command();
    write_command(1'b0, 8'h00);
    write_command(1'b1, 8'($urandom));
    read_command(1'b0, 8'h00);
    read_command(1'b1, 8'($urandom));
    unknown_opcodes();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== tb/tw_slave_model.sv ====
/* Behavioral 3W slave: frame decode, read data source and frame report */
`timescale 1ns/1ps

module tw_slave_model
  import pcl_3w_pkg::*;
(
  input  logic                 tw_clock,
  input  logic                 tw_cs,
  input  logic                 tw_dout,
  input  logic                 tw_dir,
  output logic                 tw_din,
  output int                   frame_cnt,
  output logic                 frame_rw,
  output logic [ADDR_BITS-1:0] frame_addr,
  output logic [DATA_BITS-1:0] frame_data,
  output int                   frame_bits,
  output logic                 frame_dir_ok
);

  logic [FRAME_BITS-1:0] shift_in = '0;
  logic [DATA_BITS-1:0]  rd_word  = '0;
  logic                  rw       = 1'b1;
  logic                  dir_ok   = 1'b1;
  logic                  din_bit  = 1'b0;
  int                    rise_cnt = 0;
  int                    rec_cnt  = 0;

  assign tw_din    = din_bit;
  assign frame_cnt = rec_cnt;

  // Slave register contents, spread over the whole address
  function automatic logic [DATA_BITS-1:0] slave_word(input logic [ADDR_BITS-1:0] addr);
    slave_word = DATA_BITS'(32'(addr) * 32'h9E3 + 32'h5A5A);
  endfunction

  ////////////////////////////////////////
  // Bit capture on rising edges, report when chip select rises
  always @(posedge tw_clock or posedge tw_cs)
  begin
    if (tw_cs)
    begin
      // Chip select also rises out of reset with no frame behind it
      if (rise_cnt != 0)
      begin
        frame_rw     = rw;
        frame_addr   = shift_in[FRAME_BITS-2 -: ADDR_BITS];
        frame_data   = rw ? shift_in[DATA_BITS-1:0] : rd_word;
        frame_bits   = rise_cnt;
        frame_dir_ok = dir_ok;
        rec_cnt      = rec_cnt + 1;
      end
      rise_cnt = 0;
      shift_in = '0;
      dir_ok   = 1'b1;
    end
    else
    begin
      rise_cnt = rise_cnt + 1;
      shift_in = {shift_in[FRAME_BITS-2:0], tw_dout};
      if (rise_cnt == 1)
        rw = tw_dout;
      // Master owns the line up to the last address bit
      if (tw_dir !== (rw || rise_cnt <= 1 + ADDR_BITS))
        dir_ok = 1'b0;
      if (!rw && rise_cnt == 1 + ADDR_BITS)
        rd_word = slave_word(shift_in[ADDR_BITS-1:0]);
    end
  end

  // Read data goes out on falling edges, MSB first
  always @(negedge tw_clock)
  begin
    if (!rw && rise_cnt >= 1 + ADDR_BITS && rise_cnt < FRAME_BITS)
      din_bit = 1'(rd_word >> (FRAME_BITS - 1 - rise_cnt));
  end

endmodule

// ==== verilog/pcl_3w_master.sv ====
/* Top level of the host to 3W bridge: decoder, serial engine and buffer */
`timescale 1ns/1ps

module pcl_3w_master (
  input  logic       in_clk,
  input  logic       in_rst,
  input  logic [7:0] data_rx,
  input  logic       rx_done,
  output logic       rx_trig,
  output logic [7:0] data_tx,
  input  logic       tx_done,
  output logic       tx_trig,
  output logic       tw_clock,
  output logic       tw_cs,
  output logic       tw_dout,
  input  logic       tw_din,
  output logic       tw_dir
);

  tw_req_if   req_bus ();
  buf_port_if dec_port ();
  buf_port_if eng_port ();

  // Host side protocol
  pcl_cmd_decoder u_decoder (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .data_rx  (data_rx),
    .rx_done  (rx_done),
    .rx_trig  (rx_trig),
    .data_tx  (data_tx),
    .tx_done  (tx_done),
    .tx_trig  (tx_trig),
    .req      (req_bus.requester),
    .mem_port (dec_port.user)
  );

  // 3W bus side
  tw_serial_engine u_engine (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .req      (req_bus.engine),
    .mem_port (eng_port.user),
    .tw_clock (tw_clock),
    .tw_cs    (tw_cs),
    .tw_dout  (tw_dout),
    .tw_din   (tw_din),
    .tw_dir   (tw_dir)
  );

  word_buffer_ram u_buffer (
    .in_clk (in_clk),
    .port_a (eng_port.mem),
    .port_b (dec_port.mem)
  );

endmodule

// ==== verilog/word_buffer_ram.sv ====
/* Dual port word buffer with registered reads */
`timescale 1ns/1ps

module word_buffer_ram
  import pcl_3w_pkg::*;
(
  input  logic    in_clk,
  buf_port_if.mem port_a,
  buf_port_if.mem port_b
);

  logic [DATA_BITS-1:0] mem [BURST_MAX];

  // Users never write in the same phase
  always_ff @(posedge in_clk)
  begin
    if (port_a.wr)
      mem[port_a.addr] <= port_a.wdata;
    if (port_b.wr)
      mem[port_b.addr] <= port_b.wdata;
  end

  always_ff @(posedge in_clk)
  begin
    port_a.rdata <= mem[port_a.addr];
  end

  always_ff @(posedge in_clk)
  begin
    port_b.rdata <= mem[port_b.addr];
  end

endmodule

// ==== threewire/tw_serial_engine.sv ====
/* 3W frame generator: clock divider, frame FSM, shift registers
   and burst sequencing through the word buffer */
`timescale 1ns/1ps

module tw_serial_engine
  import pcl_3w_pkg::*;
(
  input  logic     in_clk,
  input  logic     in_rst,
  tw_req_if.engine req,
  buf_port_if.user mem_port,
  output logic     tw_clock,
  output logic     tw_cs,
  output logic     tw_dout,
  input  logic     tw_din,
  output logic     tw_dir
);

  logic [ENG_STATE_W-1:0] state;
  logic [TW_DIV_W-1:0]    div_cnt;
  logic                   tick;
  logic                   rise_tick;
  logic                   fall_tick;
  logic                   last_bit;
  logic                   gap_half;
  logic [FRAME_CNT_W-1:0] bit_cnt;
  logic                   mode_wr;
  logic                   last_frame;
  logic [ADDR_BITS-1:0]   addr_cur;
  logic [BURST_W-1:0]     reps_left;
  logic [BURST_W-1:0]     slot;
  logic                   slot_adv;
  logic [FRAME_BITS-1:0]  shift_reg;
  logic [DATA_BITS-1:0]   rx_word;

  assign tick      = (state != ES_IDLE) && (div_cnt == TW_DIV_W'(TW_HALF_PERIOD - 1));
  assign rise_tick = tick && (state == ES_FRAME) && !tw_clock;
  assign fall_tick = tick && (state == ES_FRAME) && tw_clock;
  assign last_bit  = (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1));

  assign mem_port.addr  = slot;
  assign mem_port.wdata = rx_word;
  // Line held low while deselected
  assign tw_dout = shift_reg[FRAME_BITS-1] & ~tw_cs;

  // Half period divider
  always_ff @(posedge in_clk or posedge in_rst)
  begin
    if (in_rst)
      div_cnt <= '0;
    else if (state == ES_IDLE || tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  ////////////////////////////////////////
  // Frame sequencing
  always_ff @(posedge in_clk or posedge in_rst)
  begin
    if (in_rst)
    begin
      state       <= ES_IDLE;
      req.busy    <= 1'b0;
      tw_clock    <= 1'b0;
      tw_cs       <= 1'b1;
      tw_dir      <= 1'b1;
      gap_half    <= 1'b0;
      bit_cnt     <= '0;
      mode_wr     <= 1'b0;
      last_frame  <= 1'b0;
      addr_cur    <= '0;
      reps_left   <= '0;
      slot        <= '0;
      slot_adv    <= 1'b0;
      mem_port.wr <= 1'b0;
    end
    else
    begin
      // Read data is stored before the slot moves on
      if (slot_adv)
      begin
        slot_adv    <= 1'b0;
        mem_port.wr <= 1'b0;
        slot        <= slot + 1'b1;
      end

      case (state)
        ES_IDLE:
        begin
          if (req.start)
          begin
            req.busy   <= 1'b1;
            mode_wr    <= req.mode_wr;
            addr_cur   <= req.addr;
            reps_left  <= req.burst_reps;
            last_frame <= 1'b0;
            slot       <= '0;
            gap_half   <= 1'b0;
            state      <= ES_GAP;
          end
        end

        // One full 3W period with chip select high
        ES_GAP:
        begin
          if (tick)
          begin
            if (!gap_half)
              gap_half <= 1'b1;
            else
            begin
              gap_half <= 1'b0;
              if (last_frame)
              begin
                req.busy <= 1'b0;
                state    <= ES_IDLE;
              end
              else
                state <= ES_LOAD;
            end
          end
        end

        ES_LOAD:
        begin
          tw_cs   <= 1'b0;
          bit_cnt <= '0;
          state   <= ES_FRAME;
        end

        ES_FRAME:
        begin
          if (rise_tick)
            tw_clock <= 1'b1;
          else if (fall_tick)
          begin
            tw_clock <= 1'b0;
            if (last_bit)
            begin
              tw_cs       <= 1'b1;
              tw_dir      <= 1'b1;
              mem_port.wr <= !mode_wr;
              slot_adv    <= 1'b1;
              addr_cur    <= addr_cur + 1'b1;
              last_frame  <= (reps_left == '0);
              reps_left   <= reps_left - 1'b1;
              state       <= ES_GAP;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              // Hand the line to the slave after the last address bit
              if (!mode_wr && bit_cnt == FRAME_CNT_W'(ADDR_BITS))
                tw_dir <= 1'b0;
            end
          end
        end

        default:
          state <= ES_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Shift registers
  always_ff @(posedge in_clk)
  begin
    if (state == ES_LOAD)
      shift_reg <= {mode_wr, addr_cur, (mode_wr ? mem_port.rdata : DATA_BITS'(0))};
    else if (fall_tick)
      shift_reg <= shift_reg << 1;

    // Data phase samples on rising edges
    if (rise_tick && bit_cnt > FRAME_CNT_W'(ADDR_BITS))
      rx_word <= {rx_word[DATA_BITS-2:0], tw_din};
  end

endmodule

// ==== protocol/pcl_cmd_decoder.sv ====
/* Host byte protocol FSM: command parsing, buffer fill, engine start
   and reply streaming */
`timescale 1ns/1ps

module pcl_cmd_decoder
  import pcl_3w_pkg::*;
(
  input  logic        in_clk,
  input  logic        in_rst,
  input  logic [7:0]  data_rx,
  input  logic        rx_done,
  output logic        rx_trig,
  output logic [7:0]  data_tx,
  input  logic        tx_done,
  output logic        tx_trig,
  tw_req_if.requester req,
  buf_port_if.user    mem_port
);

  logic [DEC_STATE_W-1:0] state;
  logic [BYTE_CNT_W-1:0]  byte_cnt;
  logic [BURST_W-1:0]     burst_ctr;
  cmd_byte_u              cmd_in;

  assign cmd_in = cmd_byte_u'(data_rx);

  always_ff @(posedge in_clk or posedge in_rst)
  begin
    if (in_rst)
    begin
      state          <= DS_WAIT_CMD;
      rx_trig        <= 1'b0;
      tx_trig        <= 1'b0;
      data_tx        <= '0;
      byte_cnt       <= '0;
      burst_ctr      <= '0;
      req.start      <= 1'b0;
      req.mode_wr    <= 1'b0;
      req.addr       <= '0;
      req.burst_reps <= '0;
      mem_port.addr  <= '0;
      mem_port.wdata <= '0;
      mem_port.wr    <= 1'b0;
    end
    else
    begin
      // Strobes last one cycle
      rx_trig   <= 1'b0;
      tx_trig   <= 1'b0;
      req.start <= 1'b0;

      // Step to the next buffer slot after each write
      if (mem_port.wr)
      begin
        mem_port.wr   <= 1'b0;
        mem_port.addr <= mem_port.addr + 1'b1;
      end

      case (state)
        DS_WAIT_CMD:
        begin
          if (rx_done)
          begin
            case (cmd_in.f.opcode)
              OP_READ, OP_WRITE:
              begin
                req.mode_wr <= (cmd_in.f.opcode == OP_WRITE);
                byte_cnt    <= BYTE_CNT_W'(ADDR_BYTES - 1);
                if (cmd_in.f.burst)
                  state <= DS_WAIT_BURST;
                else
                begin
                  req.burst_reps <= '0;
                  burst_ctr      <= '0;
                  state          <= DS_WAIT_ADDR;
                end
                rx_trig <= 1'b1;
              end
              OP_PING:
              begin
                data_tx   <= {1'b0, OP_OK};
                byte_cnt  <= '0;
                burst_ctr <= '0;
                tx_trig   <= 1'b1;
                state     <= DS_SEND_ANSWER;
              end
              OP_ECHO:
              begin
                rx_trig <= 1'b1;
                state   <= DS_WAIT_ECHO;
              end
              // Unknown opcode, swallow it and ask for the next byte
              default:
                rx_trig <= 1'b1;
            endcase
          end
        end

        DS_WAIT_BURST:
        begin
          if (rx_done)
          begin
            req.burst_reps <= data_rx[BURST_W-1:0];
            burst_ctr      <= data_rx[BURST_W-1:0];
            rx_trig        <= 1'b1;
            state          <= DS_WAIT_ADDR;
          end
        end

        ////////////////////////////////////////
        // Address bytes, high bits fall off the top
        DS_WAIT_ADDR:
        begin
          if (rx_done)
          begin
            req.addr <= ADDR_BITS'({req.addr, data_rx});
            if (byte_cnt != '0)
            begin
              byte_cnt <= byte_cnt - 1'b1;
              rx_trig  <= 1'b1;
            end
            else
            begin
              mem_port.addr <= '0;
              if (req.mode_wr)
              begin
                byte_cnt <= BYTE_CNT_W'(DATA_BYTES - 1);
                rx_trig  <= 1'b1;
                state    <= DS_WAIT_WRDATA;
              end
              else
              begin
                req.start <= 1'b1;
                state     <= DS_TW_STARTED;
              end
            end
          end
        end

        DS_WAIT_WRDATA:
        begin
          if (rx_done)
          begin
            mem_port.wdata <= DATA_BITS'({mem_port.wdata, data_rx});
            if (byte_cnt != '0)
            begin
              byte_cnt <= byte_cnt - 1'b1;
              rx_trig  <= 1'b1;
            end
            else
            begin
              // Word complete
              mem_port.wr <= 1'b1;
              if (burst_ctr != '0)
              begin
                burst_ctr <= burst_ctr - 1'b1;
                byte_cnt  <= BYTE_CNT_W'(DATA_BYTES - 1);
                rx_trig   <= 1'b1;
              end
              else
              begin
                req.start <= 1'b1;
                state     <= DS_TW_STARTED;
              end
            end
          end
        end

        DS_TW_STARTED:
        begin
          if (req.busy)
            state <= DS_WAIT_COMPLETE;
        end

        DS_WAIT_COMPLETE:
        begin
          if (!req.busy)
          begin
            if (req.mode_wr)
            begin
              data_tx  <= {1'b0, OP_OK};
              byte_cnt <= '0;
            end
            else
            begin
              // Slot 0 already sits on rdata
              data_tx  <= mem_port.rdata[DATA_BITS-1 -: 8];
              byte_cnt <= BYTE_CNT_W'(DATA_BYTES - 1);
            end
            tx_trig <= 1'b1;
            state   <= DS_SEND_ANSWER;
          end
        end

        ////////////////////////////////////////
        // Reply stream
        DS_SEND_ANSWER:
        begin
          if (tx_done)
          begin
            if (byte_cnt != '0)
            begin
              data_tx  <= 8'(mem_port.rdata >> (8 * (byte_cnt - 1'b1)));
              byte_cnt <= byte_cnt - 1'b1;
              tx_trig  <= 1'b1;
              // Last byte taken, fetch the next word early
              if (byte_cnt == BYTE_CNT_W'(1))
                mem_port.addr <= mem_port.addr + 1'b1;
            end
            else if (burst_ctr != '0)
            begin
              burst_ctr <= burst_ctr - 1'b1;
              data_tx   <= mem_port.rdata[DATA_BITS-1 -: 8];
              byte_cnt  <= BYTE_CNT_W'(DATA_BYTES - 1);
              tx_trig   <= 1'b1;
            end
            else
            begin
              rx_trig <= 1'b1;
              state   <= DS_WAIT_CMD;
            end
          end
        end

        DS_WAIT_ECHO:
        begin
          if (rx_done)
          begin
            data_tx   <= cmd_in.raw;
            byte_cnt  <= '0;
            burst_ctr <= '0;
            tx_trig   <= 1'b1;
            state     <= DS_SEND_ANSWER;
          end
        end

        default:
          state <= DS_WAIT_CMD;
      endcase
    end
  end

endmodule

// ==== common/pcl_3w_if.sv ====
/* Engine request interface and word buffer port interface */
`timescale 1ns/1ps

// Decoder to serial engine request
interface tw_req_if
  import pcl_3w_pkg::*;
();
  logic                 start;
  logic                 mode_wr;
  logic [ADDR_BITS-1:0] addr;
  logic [BURST_W-1:0]   burst_reps;
  logic                 busy;

  modport requester (
    output start,
    output mode_wr,
    output addr,
    output burst_reps,
    input  busy
  );

  modport engine (
    input  start,
    input  mode_wr,
    input  addr,
    input  burst_reps,
    output busy
  );
endinterface

// One port of the word buffer, read data lags address by a cycle
interface buf_port_if
  import pcl_3w_pkg::*;
();
  logic [BURST_W-1:0]   addr;
  logic [DATA_BITS-1:0] wdata;
  logic                 wr;
  logic [DATA_BITS-1:0] rdata;

  modport user (output addr, output wdata, output wr, input rdata);
  modport mem  (input addr, input wdata, input wr, output rdata);
endinterface

// ==== common/pcl_3w_pkg.sv ====
/* Widths, opcodes, 3W timing, FSM state codes and the command byte union */
package pcl_3w_pkg;

  // 3W frame geometry
  localparam int ADDR_BITS   = 10;
  localparam int DATA_BITS   = 16;
  localparam int FRAME_BITS  = 1 + ADDR_BITS + DATA_BITS;
  localparam int FRAME_CNT_W = 5;

  // Host side framing, MSB first
  localparam int ADDR_BYTES = 2;
  localparam int DATA_BYTES = 2;
  localparam int BYTE_CNT_W = 2;

  // Burst buffer
  localparam int BURST_MAX = 32;
  localparam int BURST_W   = 5;

  // 3W clock divider
  localparam int TW_HALF_PERIOD = 4;
  localparam int TW_DIV_W       = 2;

  // Opcodes, low 7 bits of the command byte
  localparam logic [6:0] OP_READ  = 7'd0;
  localparam logic [6:0] OP_WRITE = 7'd1;
  localparam logic [6:0] OP_OK    = 7'd2;
  localparam logic [6:0] OP_ECHO  = 7'd3;
  localparam logic [6:0] OP_PING  = 7'd4;

  ////////////////////////////////////////
  // Decoder FSM
  localparam int DEC_STATE_W = 3;
  localparam logic [2:0] DS_WAIT_CMD      = 3'd0;
  localparam logic [2:0] DS_WAIT_BURST    = 3'd1;
  localparam logic [2:0] DS_WAIT_ADDR     = 3'd2;
  localparam logic [2:0] DS_WAIT_WRDATA   = 3'd3;
  localparam logic [2:0] DS_TW_STARTED    = 3'd4;
  localparam logic [2:0] DS_WAIT_COMPLETE = 3'd5;
  localparam logic [2:0] DS_SEND_ANSWER   = 3'd6;
  localparam logic [2:0] DS_WAIT_ECHO     = 3'd7;

  ////////////////////////////////////////
  // Serial engine FSM
  localparam int ENG_STATE_W = 2;
  localparam logic [1:0] ES_IDLE  = 2'd0;
  localparam logic [1:0] ES_GAP   = 2'd1;
  localparam logic [1:0] ES_LOAD  = 2'd2;
  localparam logic [1:0] ES_FRAME = 2'd3;

  // Raw byte, or burst flag plus opcode
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic       burst;
      logic [6:0] opcode;
    } f;
  } cmd_byte_u;

endpackage
